// ==== verilog/lsq_pkg.sv ====
// Shared sizes, command and state encodings and the entry layout of the load/store queue
// Every block refers to these through scoped names

package lsq_pkg;

	// ========================================================================
	// Sizes
	// ========================================================================

	// Default queue depth, overridden through the module parameters
	localparam int LSQ_ENTRIES = 8;
	// Default number of ROB ids that can own a queue entry
	localparam int ROB_ENTRIES = 16;
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// Age stamp width; stamps wrap and are compared as a signed difference
	localparam int SEQ_W = 8;

	// ========================================================================
	// Encodings
	// ========================================================================

	// One command is presented per clock, LSQ_NOP means the cycle is idle
	typedef enum logic [2:0] {
		LSQ_NOP,
		LSQ_ENQ,
		LSQ_SETADR,
		LSQ_INCADR,
		LSQ_SETRES,
		LSQ_INV
	} lsq_op_t;

	// ST_SPLIT marks an access that was moved on to the next cache line
	// ST_FWD marks a load that picked up data from a committing store
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SPLIT,
		ST_FWD
	} lsq_state_t;

	// Access size, forwarding only happens between equal sizes
	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_WYDE,
		SZ_TETRA,
		SZ_OCTA
	} mem_size_t;

	// One queue entry
	typedef struct packed {
		logic v;
		logic load;
		logic store;
		// Address generation done, padr holds the translated address
		logic agen;
		logic datav;
		// Set when a load is cancelled, so the data it already fetched stays usable
		logic loadv;
		logic [$clog2(ROB_ENTRIES)-1:0] rob_id;
		logic [SEQ_W-1:0] seq;
		mem_size_t size;
		lsq_state_t state;
		logic [ADDR_W-1:0] vadr;
		logic [ADDR_W-1:0] padr;
		// Byte offset within the line and the bytes left up to the line end
		logic [6:0] shift;
		logic [6:0] shift2;
		logic [DATA_W-1:0] res;
	} lsq_entry_t;

endpackage

// ==== verilog/lsq_cmd_if.sv ====
// Carries one decoded queue command from the top level to the map and the entry array
// The top level drives it, the queue blocks only read it

`timescale 1ns/1ps

interface lsq_cmd_if #(
	parameter int ROB_ENTRIES = lsq_pkg::ROB_ENTRIES
);

	// Valid for the single cycle in which op is not LSQ_NOP
	lsq_pkg::lsq_op_t op;
	logic [$clog2(ROB_ENTRIES)-1:0] rob_id;
	logic is_load;
	logic is_store;
	lsq_pkg::mem_size_t size;
	// Address for enqueue and set address, payload for set result and invalidate
	logic [lsq_pkg::DATA_W-1:0] data;
	// On invalidate, high when the instruction retires instead of being cancelled
	logic commit;

	modport cmd_src (
		output op,
		output rob_id,
		output is_load,
		output is_store,
		output size,
		output data,
		output commit
	);

	modport cmd_dst (
		input op,
		input rob_id,
		input is_load,
		input is_store,
		input size,
		input data,
		input commit
	);

endinterface

// ==== verilog/lsq_rob_map.sv ====
// Remembers which queue slot each ROB id was given at enqueue
// Looks the slot up for the current command and, on a second port, for the query

`timescale 1ns/1ps

module lsq_rob_map #(
	parameter int LSQ_ENTRIES = lsq_pkg::LSQ_ENTRIES,
	parameter int ROB_ENTRIES = lsq_pkg::ROB_ENTRIES
) (
	input logic clk,
	input logic rst,
	lsq_cmd_if.cmd_dst cmd,
	input logic [$clog2(LSQ_ENTRIES)-1:0] tail,
	output logic [$clog2(LSQ_ENTRIES)-1:0] ndx,
	input logic [$clog2(ROB_ENTRIES)-1:0] query_id,
	output logic [$clog2(LSQ_ENTRIES)-1:0] query_ndx
);

	localparam int NDX_W = $clog2(LSQ_ENTRIES);

	// One slot number per ROB id
	logic [NDX_W-1:0] map [ROB_ENTRIES];

	// The slot being filled is the tail at the moment of enqueue
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				map[i] <= '0;
			end
		end
		else if (cmd.op == lsq_pkg::LSQ_ENQ) begin
			map[cmd.rob_id] <= tail;
		end
	end

	// Later commands name their entry by ROB id only
	// This read replaces an associative search of the queue
	assign ndx = map[cmd.rob_id];

	// Second read port for the status outputs
	assign query_ndx = map[query_id];

endmodule

// ==== verilog/lsq_entries.sv ====
// The ring of load/store queue entries with its tail pointer and age counter
// Applies every command to the entry the ROB map selects, and store forwards on commit

`timescale 1ns/1ps

module lsq_entries #(
	parameter int LSQ_ENTRIES = lsq_pkg::LSQ_ENTRIES,
	parameter int ROB_ENTRIES = lsq_pkg::ROB_ENTRIES
) (
	input logic clk,
	input logic rst,
	lsq_cmd_if.cmd_dst cmd,
	input logic [$clog2(LSQ_ENTRIES)-1:0] ndx,
	input logic [LSQ_ENTRIES-1:0] fwd_mask,
	output lsq_pkg::lsq_entry_t entries [LSQ_ENTRIES],
	output logic [$clog2(LSQ_ENTRIES)-1:0] tail
);

	localparam int NDX_W = $clog2(LSQ_ENTRIES);
	localparam int ROB_W = $clog2(ROB_ENTRIES);
	localparam int ADDR_W = lsq_pkg::ADDR_W;
	localparam int SEQ_W = lsq_pkg::SEQ_W;

	// Free-running enqueue counter, its value is the age stamp of the new entry
	logic [SEQ_W-1:0] age_cnt;
	logic [NDX_W-1:0] tail_next;
	logic [ROB_W-1:0] enq_rob_id;
	lsq_pkg::lsq_entry_t enq_entry;
	// Entry addressed by the current command
	lsq_pkg::lsq_entry_t sel;
	logic [ADDR_W-1:0] cmd_adr;
	logic commit_store;

	// ========================================================================
	// Combinational helpers
	// ========================================================================

	// The ring need not be a power of two, so wrap explicitly
	assign tail_next = (tail == NDX_W'(LSQ_ENTRIES - 1)) ? '0 : tail + 1'b1;

	assign enq_rob_id = cmd.rob_id;
	assign sel = entries[ndx];
	assign cmd_adr = cmd.data[ADDR_W-1:0];

	// The forward search runs on every cycle, its mask only counts when a
	// store retires
	assign commit_store = (cmd.op == lsq_pkg::LSQ_INV) && cmd.commit && sel.store;

	// Fresh entry for enqueue
	// Data fields start cleared until address generation and execute fill them
	always_comb begin
		enq_entry = '0;
		enq_entry.v = 1'b1;
		enq_entry.load = cmd.is_load;
		enq_entry.store = cmd.is_store;
		enq_entry.agen = 1'b0;
		enq_entry.rob_id = enq_rob_id;
		enq_entry.seq = age_cnt;
		enq_entry.size = cmd.size;
		enq_entry.state = lsq_pkg::ST_IDLE;
		enq_entry.vadr = cmd_adr;
		enq_entry.res = '0;
	end

	// ========================================================================
	// Queue state
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
			age_cnt <= '0;
			for (int i = 0; i < LSQ_ENTRIES; i++) begin
				entries[i] <= '0;
			end
		end
		else begin
			case (cmd.op)
				lsq_pkg::LSQ_ENQ: begin
					// Enqueue always lands on the tail, the map records the slot
					entries[tail] <= enq_entry;
					tail <= tail_next;
					age_cnt <= age_cnt + 1'b1;
				end

				lsq_pkg::LSQ_SETADR: begin
					entries[ndx].padr <= cmd_adr;
					entries[ndx].agen <= 1'b1;
					// A split access keeps the shift of its first half
					if (sel.state == lsq_pkg::ST_IDLE) begin
						entries[ndx].shift <= {1'b0, cmd_adr[5:0]};
						entries[ndx].shift2 <= 7'd64 - {1'b0, cmd_adr[5:0]};
					end
				end

				lsq_pkg::LSQ_INCADR: begin
					// Second half of a line crossing access starts at the next
					// 64 byte line and needs translating again
					entries[ndx].vadr <= {sel.vadr[ADDR_W-1:6] + 1'b1, 6'd0};
					entries[ndx].agen <= 1'b0;
					entries[ndx].state <= lsq_pkg::ST_SPLIT;
				end

				lsq_pkg::LSQ_SETRES: begin
					entries[ndx].res <= cmd.data;
					entries[ndx].datav <= 1'b1;
				end

				lsq_pkg::LSQ_INV: begin
					entries[ndx].v <= 1'b0;
					entries[ndx].load <= 1'b0;
					entries[ndx].store <= 1'b0;
					entries[ndx].agen <= 1'b0;
					entries[ndx].datav <= 1'b0;
					entries[ndx].state <= lsq_pkg::ST_IDLE;
					entries[ndx].res <= cmd.data;
					// A cancelled load keeps its data marked as usable
					entries[ndx].loadv <= !cmd.commit && sel.load;

					// Retiring store hands its old data to the loads it feeds
					// The mask never selects the store itself, so there is no
					// clash with the writes above
					if (commit_store) begin
						for (int i = 0; i < LSQ_ENTRIES; i++) begin
							if (fwd_mask[i]) begin
								entries[i].res <= sel.res;
								entries[i].state <= lsq_pkg::ST_FWD;
							end
						end
					end
				end

				default: begin
				end
			endcase
		end
	end

endmodule

// ==== verilog/lsq_store_forward.sv ====
// Finds the loads that a given store should feed when it retires
// Pure combinational search over the whole queue, gated by the entry array

`timescale 1ns/1ps

module lsq_store_forward #(
	parameter int LSQ_ENTRIES = lsq_pkg::LSQ_ENTRIES
) (
	input lsq_pkg::lsq_entry_t entries [LSQ_ENTRIES],
	input logic [$clog2(LSQ_ENTRIES)-1:0] store_ndx,
	output logic [LSQ_ENTRIES-1:0] fwd_mask
);

	localparam int SEQ_W = lsq_pkg::SEQ_W;

	lsq_pkg::lsq_entry_t st;
	// Valid stores to the same size and address as the selected store
	logic [LSQ_ENTRIES-1:0] alias_store;
	// Valid loads younger than the store with the same size and address
	logic [LSQ_ENTRIES-1:0] cand_load;
	// A closer store sits between the selected store and the load
	logic [LSQ_ENTRIES-1:0] shadowed;

	// Age test on wrapping stamps
	// Stamps in flight are never more than half the range apart
	function automatic logic younger(
		input logic [SEQ_W-1:0] a,
		input logic [SEQ_W-1:0] b
	);
		logic [SEQ_W-1:0] d;
		d = a - b;
		return (d != '0) && !d[SEQ_W-1];
	endfunction

	assign st = entries[store_ndx];

	// ========================================================================
	// Matching
	// ========================================================================

	always_comb begin
		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			alias_store[i] = entries[i].v && entries[i].store &&
				(entries[i].size == st.size) && (entries[i].padr == st.padr);
			cand_load[i] = entries[i].v && entries[i].load &&
				younger(entries[i].seq, st.seq) &&
				(entries[i].size == st.size) && (entries[i].padr == st.padr);
		end
	end

	// For each load, look for an aliasing store between it and the selected
	// store; that store would be the one to feed it instead
	always_comb begin
		for (int l = 0; l < LSQ_ENTRIES; l++) begin
			shadowed[l] = 1'b0;
			for (int s = 0; s < LSQ_ENTRIES; s++) begin
				if (alias_store[s] && (s != int'(store_ndx)) &&
					younger(entries[s].seq, st.seq) &&
					younger(entries[l].seq, entries[s].seq)) begin
					shadowed[l] = 1'b1;
				end
			end
		end
	end

	// Commit and the store flag are checked by the entry array
	assign fwd_mask = cand_load & ~shadowed;

endmodule

// ==== verilog/lsq_top.sv ====
// Top level of the load/store queue subsystem
// Takes one command per clock on plain ports and shows the entry of query_rob_id

`timescale 1ns/1ps

module lsq_top #(
	parameter int LSQ_ENTRIES = lsq_pkg::LSQ_ENTRIES,
	parameter int ROB_ENTRIES = lsq_pkg::ROB_ENTRIES
) (
	input logic clk,
	input logic rst,
	input lsq_pkg::lsq_op_t cmd_op,
	input logic [$clog2(ROB_ENTRIES)-1:0] cmd_rob_id,
	input logic cmd_is_load,
	input logic cmd_is_store,
	input lsq_pkg::mem_size_t cmd_size,
	input logic [lsq_pkg::DATA_W-1:0] cmd_data,
	input logic cmd_commit,
	input logic [$clog2(ROB_ENTRIES)-1:0] query_rob_id,
	output logic [$clog2(LSQ_ENTRIES)-1:0] tail,
	output logic query_valid,
	output lsq_pkg::lsq_state_t query_state,
	output logic query_agen,
	output logic query_datav,
	output logic query_loadv,
	output logic [lsq_pkg::ADDR_W-1:0] query_vadr,
	output logic [lsq_pkg::ADDR_W-1:0] query_padr,
	output logic [6:0] query_shift,
	output logic [lsq_pkg::DATA_W-1:0] query_res
);

	localparam int NDX_W = $clog2(LSQ_ENTRIES);

	lsq_pkg::lsq_entry_t entries [LSQ_ENTRIES];
	// Slot of the current command, also the store searched on invalidate
	logic [NDX_W-1:0] ndx;
	logic [NDX_W-1:0] query_ndx;
	logic [LSQ_ENTRIES-1:0] fwd_mask;

	// Command bundle, driven from the pins as its source side
	lsq_cmd_if #(.ROB_ENTRIES(ROB_ENTRIES)) cmd_if ();

	assign cmd_if.op = cmd_op;
	assign cmd_if.rob_id = cmd_rob_id;
	assign cmd_if.is_load = cmd_is_load;
	assign cmd_if.is_store = cmd_is_store;
	assign cmd_if.size = cmd_size;
	assign cmd_if.data = cmd_data;
	assign cmd_if.commit = cmd_commit;

	lsq_rob_map #(.LSQ_ENTRIES(LSQ_ENTRIES), .ROB_ENTRIES(ROB_ENTRIES)) rob_map_i (
		.clk(clk), .rst(rst), .cmd(cmd_if.cmd_dst), .tail(tail), .ndx(ndx),
		.query_id(query_rob_id), .query_ndx(query_ndx)
	);

	lsq_entries #(.LSQ_ENTRIES(LSQ_ENTRIES), .ROB_ENTRIES(ROB_ENTRIES)) entries_i (
		.clk(clk), .rst(rst), .cmd(cmd_if.cmd_dst), .ndx(ndx),
		.fwd_mask(fwd_mask), .entries(entries), .tail(tail)
	);

	lsq_store_forward #(.LSQ_ENTRIES(LSQ_ENTRIES)) store_forward_i (
		.entries(entries), .store_ndx(ndx), .fwd_mask(fwd_mask)
	);

	// Status of the queried entry, one cycle behind the command that changed it
	assign query_valid = entries[query_ndx].v;
	assign query_state = entries[query_ndx].state;
	assign query_agen = entries[query_ndx].agen;
	assign query_datav = entries[query_ndx].datav;
	assign query_loadv = entries[query_ndx].loadv;
	assign query_vadr = entries[query_ndx].vadr;
	assign query_padr = entries[query_ndx].padr;
	assign query_shift = entries[query_ndx].shift;
	assign query_res = entries[query_ndx].res;

endmodule

// ==== tb/lsq_tb_table.svh ====
// Command table for the load/store queue testbench, included into the testbench module
// Each add_cmd line is one command and an expect_row after it checks the queried entry

// The add_cmd columns are op, rob id, {load, store}, size, data and commit
// The expect_row columns are rob id, tail, {valid, agen, datav, loadv}, state,
// vadr, padr, shift and res
task automatic fill_table();
	// Reset leaves every entry empty and the tail at zero
	add_cmd(NOP, 4'd0, 2'b00, BYTE, 64'h0, 1'b0);
	expect_row(4'd0, 3'd0, 4'b0000, IDLE, 32'h0, 32'h0, 7'd0, 64'h0);

	// Load in slot 0 that crosses a line and is then cancelled
	add_cmd(ENQ, 4'd1, 2'b10, OCTA, 64'h1000_0038, 1'b0);
	expect_row(4'd1, 3'd1, 4'b1000, IDLE, 32'h1000_0038, 32'h0, 7'd0, 64'h0);
	add_cmd(SETADR, 4'd1, 2'b00, OCTA, 64'h0000_2038, 1'b0);
	expect_row(4'd1, 3'd1, 4'b1100, IDLE, 32'h1000_0038, 32'h0000_2038, 7'd56, 64'h0);
	add_cmd(INCADR, 4'd1, 2'b00, OCTA, 64'h0, 1'b0);
	expect_row(4'd1, 3'd1, 4'b1000, SPLIT, 32'h1000_0040, 32'h0000_2038, 7'd56, 64'h0);
	// Second half of the split keeps the shift of the first half
	add_cmd(SETADR, 4'd1, 2'b00, OCTA, 64'h0000_2040, 1'b0);
	expect_row(4'd1, 3'd1, 4'b1100, SPLIT, 32'h1000_0040, 32'h0000_2040, 7'd56, 64'h0);
	add_cmd(SETRES, 4'd1, 2'b00, OCTA, 64'h5a5a_0001, 1'b0);
	expect_row(4'd1, 3'd1, 4'b1110, SPLIT, 32'h1000_0040, 32'h0000_2040, 7'd56, 64'h5a5a_0001);
	add_cmd(INV, 4'd1, 2'b00, OCTA, 64'h5a5a_00ff, 1'b0);
	expect_row(4'd1, 3'd1, 4'b0001, IDLE, 32'h1000_0040, 32'h0000_2040, 7'd56, 64'h5a5a_00ff);

	// Two stores to one address, then an octa load and a tetra load to it
	add_cmd(ENQ, 4'd2, 2'b01, OCTA, 64'h3000, 1'b0);
	expect_row(4'd2, 3'd2, 4'b1000, IDLE, 32'h3000, 32'h0, 7'd0, 64'h0);
	add_cmd(SETADR, 4'd2, 2'b00, OCTA, 64'h4000, 1'b0);
	add_cmd(SETRES, 4'd2, 2'b00, OCTA, 64'haaaa_0002, 1'b0);
	add_cmd(ENQ, 4'd3, 2'b01, OCTA, 64'h3000, 1'b0);
	add_cmd(SETADR, 4'd3, 2'b00, OCTA, 64'h4000, 1'b0);
	add_cmd(SETRES, 4'd3, 2'b00, OCTA, 64'hbbbb_0003, 1'b0);
	expect_row(4'd3, 3'd3, 4'b1110, IDLE, 32'h3000, 32'h4000, 7'd0, 64'hbbbb_0003);
	add_cmd(ENQ, 4'd4, 2'b10, OCTA, 64'h3000, 1'b0);
	add_cmd(SETADR, 4'd4, 2'b00, OCTA, 64'h4000, 1'b0);
	expect_row(4'd4, 3'd4, 4'b1100, IDLE, 32'h3000, 32'h4000, 7'd0, 64'h0);
	add_cmd(ENQ, 4'd5, 2'b10, TETRA, 64'h3000, 1'b0);
	add_cmd(SETADR, 4'd5, 2'b00, OCTA, 64'h4000, 1'b0);

	// The older store retires first and the younger store shadows the load
	add_cmd(INV, 4'd2, 2'b00, OCTA, 64'h0, 1'b1);
	expect_row(4'd4, 3'd5, 4'b1100, IDLE, 32'h3000, 32'h4000, 7'd0, 64'h0);
	// Younger store retires and feeds the octa load
	add_cmd(INV, 4'd3, 2'b00, OCTA, 64'h0, 1'b1);
	expect_row(4'd4, 3'd5, 4'b1100, FWD, 32'h3000, 32'h4000, 7'd0, 64'hbbbb_0003);
	add_cmd(NOP, 4'd5, 2'b00, BYTE, 64'h0, 1'b0);
	expect_row(4'd5, 3'd5, 4'b1100, IDLE, 32'h3000, 32'h4000, 7'd0, 64'h0);
	// A committed store leaves loadv low
	add_cmd(NOP, 4'd3, 2'b00, BYTE, 64'h0, 1'b0);
	expect_row(4'd3, 3'd5, 4'b0000, IDLE, 32'h3000, 32'h4000, 7'd0, 64'h0);

	// Eight enqueues in total bring the tail back round to slot 0
	add_cmd(ENQ, 4'd6, 2'b10, BYTE, 64'h5001, 1'b0);
	expect_row(4'd6, 3'd6, 4'b1000, IDLE, 32'h5001, 32'h0, 7'd0, 64'h0);
	add_cmd(ENQ, 4'd7, 2'b01, WYDE, 64'h5002, 1'b0);
	add_cmd(ENQ, 4'd8, 2'b10, OCTA, 64'h5008, 1'b0);
	expect_row(4'd8, 3'd0, 4'b1000, IDLE, 32'h5008, 32'h0, 7'd0, 64'h0);
	add_cmd(ENQ, 4'd9, 2'b10, OCTA, 64'h6000, 1'b0);
	expect_row(4'd9, 3'd1, 4'b1000, IDLE, 32'h6000, 32'h0, 7'd0, 64'h0);
endtask

// ==== tb/lsq_tb.sv ====
// Testbench for the load/store queue top level
// Applies the command table row by row and checks the queried entry after each command

`timescale 1ns/1ps

module lsq_tb;

	localparam int NDX_W = $clog2(lsq_pkg::LSQ_ENTRIES);
	localparam int ROB_W = $clog2(lsq_pkg::ROB_ENTRIES);
	localparam int ADDR_W = lsq_pkg::ADDR_W;
	localparam int DATA_W = lsq_pkg::DATA_W;
	localparam int MAX_ROWS = 64;
	// Longest wait in ns for one falling edge of the 40 ns clock
	localparam int EDGE_TIMEOUT = 100;

	// Short names for the table rows
	localparam lsq_pkg::lsq_op_t NOP = lsq_pkg::LSQ_NOP;
	localparam lsq_pkg::lsq_op_t ENQ = lsq_pkg::LSQ_ENQ;
	localparam lsq_pkg::lsq_op_t SETADR = lsq_pkg::LSQ_SETADR;
	localparam lsq_pkg::lsq_op_t INCADR = lsq_pkg::LSQ_INCADR;
	localparam lsq_pkg::lsq_op_t SETRES = lsq_pkg::LSQ_SETRES;
	localparam lsq_pkg::lsq_op_t INV = lsq_pkg::LSQ_INV;
	localparam lsq_pkg::mem_size_t BYTE = lsq_pkg::SZ_BYTE;
	localparam lsq_pkg::mem_size_t WYDE = lsq_pkg::SZ_WYDE;
	localparam lsq_pkg::mem_size_t TETRA = lsq_pkg::SZ_TETRA;
	localparam lsq_pkg::mem_size_t OCTA = lsq_pkg::SZ_OCTA;
	localparam lsq_pkg::lsq_state_t IDLE = lsq_pkg::ST_IDLE;
	localparam lsq_pkg::lsq_state_t SPLIT = lsq_pkg::ST_SPLIT;
	localparam lsq_pkg::lsq_state_t FWD = lsq_pkg::ST_FWD;

	// One command and, when chk is set, the expected query result after it
	typedef struct packed {
		lsq_pkg::lsq_op_t op;
		logic [ROB_W-1:0] rob_id;
		// Load flag in bit 1, store flag in bit 0
		logic [1:0] kind;
		lsq_pkg::mem_size_t size;
		logic [DATA_W-1:0] data;
		logic commit;
		logic chk;
		logic [ROB_W-1:0] qid;
		logic [NDX_W-1:0] tail;
		// Valid, agen, datav and loadv from the top bit down
		logic [3:0] flags;
		lsq_pkg::lsq_state_t state;
		logic [ADDR_W-1:0] vadr;
		logic [ADDR_W-1:0] padr;
		logic [6:0] shift;
		logic [DATA_W-1:0] res;
	} row_t;

	row_t rows [MAX_ROWS];
	int n_rows;

	logic clk;
	logic rst;
	lsq_pkg::lsq_op_t cmd_op;
	logic [ROB_W-1:0] cmd_rob_id;
	logic cmd_is_load;
	logic cmd_is_store;
	lsq_pkg::mem_size_t cmd_size;
	logic [DATA_W-1:0] cmd_data;
	logic cmd_commit;
	logic [ROB_W-1:0] query_rob_id;
	logic [NDX_W-1:0] tail;
	logic query_valid;
	lsq_pkg::lsq_state_t query_state;
	logic query_agen;
	logic query_datav;
	logic query_loadv;
	logic [ADDR_W-1:0] query_vadr;
	logic [ADDR_W-1:0] query_padr;
	logic [6:0] query_shift;
	logic [DATA_W-1:0] query_res;

	lsq_top lsq_top_i (
		.clk(clk), .rst(rst), .cmd_op(cmd_op), .cmd_rob_id(cmd_rob_id),
		.cmd_is_load(cmd_is_load), .cmd_is_store(cmd_is_store), .cmd_size(cmd_size),
		.cmd_data(cmd_data), .cmd_commit(cmd_commit), .query_rob_id(query_rob_id),
		.tail(tail), .query_valid(query_valid), .query_state(query_state),
		.query_agen(query_agen), .query_datav(query_datav), .query_loadv(query_loadv),
		.query_vadr(query_vadr), .query_padr(query_padr), .query_shift(query_shift),
		.query_res(query_res)
	);

	always #20 clk = ~clk;

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %0b got %0b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_state(input string name, input lsq_pkg::lsq_state_t exp,
		input lsq_pkg::lsq_state_t act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_ndx(input string name, input logic [NDX_W-1:0] exp,
		input logic [NDX_W-1:0] act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	// Returns on the next falling clock edge, or stops the run if none comes
	// The low phase only counts once the high phase before it was seen
	task automatic wait_fall();
		int waited;
		logic seen_high;
		waited = 0;
		seen_high = (clk === 1'b1);
		while (!(seen_high && (clk === 1'b0))) begin
			if (waited >= EDGE_TIMEOUT) begin
				$display("Timed out waiting for a falling clock edge");
				abort_run();
			end
			else begin
				#1;
				waited++;
				if (clk === 1'b1) begin
					seen_high = 1'b1;
				end
			end
		end
	endtask

	task automatic add_cmd(input lsq_pkg::lsq_op_t op, input logic [ROB_W-1:0] rob_id,
		input logic [1:0] kind, input lsq_pkg::mem_size_t size,
		input logic [DATA_W-1:0] data, input logic commit);
		if (n_rows >= MAX_ROWS) begin
			$display("The command table has more rows than the testbench can hold");
			abort_run();
		end
		else begin
			rows[n_rows] = '0;
			rows[n_rows].op = op;
			rows[n_rows].rob_id = rob_id;
			rows[n_rows].kind = kind;
			rows[n_rows].size = size;
			rows[n_rows].data = data;
			rows[n_rows].commit = commit;
			rows[n_rows].qid = rob_id;
			n_rows++;
		end
	endtask

	// Attaches the expected query result to the last command
	task automatic expect_row(input logic [ROB_W-1:0] qid, input logic [NDX_W-1:0] exp_tail,
		input logic [3:0] flags, input lsq_pkg::lsq_state_t state,
		input logic [ADDR_W-1:0] vadr, input logic [ADDR_W-1:0] padr,
		input logic [6:0] shift, input logic [DATA_W-1:0] res);
		rows[n_rows-1].chk = 1'b1;
		rows[n_rows-1].qid = qid;
		rows[n_rows-1].tail = exp_tail;
		rows[n_rows-1].flags = flags;
		rows[n_rows-1].state = state;
		rows[n_rows-1].vadr = vadr;
		rows[n_rows-1].padr = padr;
		rows[n_rows-1].shift = shift;
		rows[n_rows-1].res = res;
	endtask

	`include "lsq_tb_table.svh"

	task automatic drive_row(input row_t r);
		cmd_op = r.op;
		cmd_rob_id = r.rob_id;
		cmd_is_load = r.kind[1];
		cmd_is_store = r.kind[0];
		cmd_size = r.size;
		cmd_data = r.data;
		cmd_commit = r.commit;
		query_rob_id = r.qid;
	endtask

	task automatic compare_row(input row_t r);
		check_ndx("tail", r.tail, tail);
		check_flag("query_valid", r.flags[3], query_valid);
		check_flag("query_agen", r.flags[2], query_agen);
		check_flag("query_datav", r.flags[1], query_datav);
		check_flag("query_loadv", r.flags[0], query_loadv);
		check_state("query_state", r.state, query_state);
		check_data("query_vadr", DATA_W'(r.vadr), DATA_W'(query_vadr));
		check_data("query_padr", DATA_W'(r.padr), DATA_W'(query_padr));
		check_data("query_shift", DATA_W'(r.shift), DATA_W'(query_shift));
		check_data("query_res", r.res, query_res);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cmd_op = NOP;
		cmd_rob_id = '0;
		cmd_is_load = 1'b0;
		cmd_is_store = 1'b0;
		cmd_size = BYTE;
		cmd_data = '0;
		cmd_commit = 1'b0;
		query_rob_id = '0;
		n_rows = 0;
		fill_table();

		// Two rising edges see reset high before it drops on a falling edge
		wait_fall();
		wait_fall();
		rst = 1'b0;

		// Each command is sampled on the rising edge in the middle of its row
		for (int r = 0; r < n_rows; r++) begin
			drive_row(rows[r]);
			wait_fall();
			if (rows[r].chk) begin
				compare_row(rows[r]);
			end
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== lsq_top.f ====
+incdir+tb
verilog/lsq_pkg.sv
verilog/lsq_cmd_if.sv
verilog/lsq_rob_map.sv
verilog/lsq_entries.sv
verilog/lsq_store_forward.sv
verilog/lsq_top.sv
tb/lsq_tb.sv
